//--- all.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_apb_port.sv
rtl/csr_trap_regs.sv
rtl/csr_timer.sv
rtl/csr_sys_regs.sv
rtl/csr_read_select.sv
rtl/csr_top.sv
sim/tb_clk_gen.sv
sim/tb_csr_top.sv

//--- Makefile
TOP := tb_csr_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q '^\*\* PASS \*\*$$' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- sim/tb_csr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module tb_csr_top
    import csr_pkg::*;
();

    logic                        clk;
    logic                        aresetn;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    csr_addr_t                   paddr;
    csr_word_t                   pwdata;
    csr_word_t                   prdata;
    logic                        pready;
    logic                        pslverr;
    csr_trap_t                   trap;
    logic [`CSR_HW_IRQ_BITS-1:0] hw_irq;
    csr_word_t                   crmd_out;
    csr_word_t                   era_out;
    csr_word_t                   eentry_out;
    logic                        cpu_interrupt;

    // Expected register contents by CSR address
    csr_word_t   model [0:16383];
    logic [31:0] seed = 32'h12d9;
    int          checks;
    int          mismatches;
    int          timeouts;
    string       word_name [$];
    csr_word_t   word_exp [$];
    csr_word_t   word_act [$];
    string       bit_name [$];
    logic        bit_exp [$];
    logic        bit_act [$];

    csr_addr_t data_regs [9] = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
                                 `CSR_TID, `CSR_ERA, `CSR_BADV, `CSR_EENTRY, `CSR_ECFG};
    csr_addr_t bad_addrs [6] = '{14'h002, 14'h003, 14'h043, 14'h045, 14'h100, 14'h3FFF};

    tb_clk_gen u_clk_gen (
        .clk     (clk),
        .aresetn (aresetn)
    );

    csr_top u_csr_top (
        .clk           (clk),
        .aresetn       (aresetn),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .trap          (trap),
        .hw_irq        (hw_irq),
        .crmd_out      (crmd_out),
        .era_out       (era_out),
        .eentry_out    (eentry_out),
        .cpu_interrupt (cpu_interrupt)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic csr_word_t next_random();
        seed = xorshift32(seed);
        return seed;
    endfunction

    function automatic logic is_mapped(input csr_addr_t addr);
        case (addr)
            `CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA, `CSR_BADV,
            `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
            `CSR_TID, `CSR_TCFG, `CSR_TVAL, `CSR_TICLR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Register value after a software write
    function automatic csr_word_t ref_write(input csr_addr_t addr, input csr_word_t old,
                                            input csr_word_t data);
        csr_word_t v;
        v = old;
        case (addr)
            `CSR_CRMD: begin
                v[2:0] = data[2:0];
                // DA/PG only for one-hot pairs
                if (data[3] != data[4]) begin
                    v[4:3] = data[4:3];
                end
            end
            `CSR_PRMD:   v = data & 32'h0000_0007;
            `CSR_ECFG:   v = data & 32'h0000_1FFF;
            `CSR_ESTAT:  v[1:0] = data[1:0];
            `CSR_EENTRY: v = data & 32'hFFFF_FFC0;
            `CSR_ERA, `CSR_BADV, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
            `CSR_TID, `CSR_TCFG: v = data;
            default: v = old;
        endcase
        return v;
    endfunction

    function automatic logic ref_irq(input csr_word_t crmd, input csr_word_t ecfg,
                                     input csr_word_t estat);
        return crmd[2] && (|(ecfg[12:0] & estat[12:0]));
    endfunction

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic check_word(input string name, input csr_word_t exp, input csr_word_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic expect_word(input string name, input csr_word_t exp, input csr_word_t act);
        word_name.push_back(name);
        word_exp.push_back(exp);
        word_act.push_back(act);
    endtask

    task automatic expect_bit(input string name, input logic exp, input logic act);
        bit_name.push_back(name);
        bit_exp.push_back(exp);
        bit_act.push_back(act);
    endtask

    // Comparison process draining results queued by the stimulus
    always @(posedge clk) begin
        while (word_name.size() > 0) begin
            check_word(word_name.pop_front(), word_exp.pop_front(), word_act.pop_front());
        end
        while (bit_name.size() > 0) begin
            check_bit(bit_name.pop_front(), bit_exp.pop_front(), bit_act.pop_front());
        end
    end

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (pready !== 1'b1 && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (pready !== 1'b1) begin
            timeouts++;
            $display("APB transfer to %h got no pready within 8 cycles", paddr);
        end
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic bus_transfer(input logic write, input csr_addr_t addr, input csr_word_t wdata,
                                output csr_word_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        expect_bit("pready in setup", 1'b0, pready);
        @(posedge clk);
        #1;
        penable = 1'b1;
        wait_ready();
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input string name, input csr_addr_t addr, input csr_word_t data);
        csr_word_t rd;
        logic      err;
        bus_transfer(1'b1, addr, data, rd, err);
        model[addr] = ref_write(addr, model[addr], data);
        expect_bit({name, " write pslverr"}, !is_mapped(addr), err);
    endtask

    task automatic read_and_compare(input string name, input csr_addr_t addr);
        csr_word_t rd;
        logic      err;
        bus_transfer(1'b0, addr, 32'h0, rd, err);
        expect_word(name, is_mapped(addr) ? model[addr] : 32'h0, rd);
        expect_bit({name, " read pslverr"}, !is_mapped(addr), err);
    endtask

    task automatic pulse_trap(input csr_trap_t t);
        trap = t;
        @(posedge clk);
        #1;
        trap = '0;
    endtask

    task automatic sample_outputs(input string name);
        @(negedge clk);
        expect_word({name, " crmd_out"}, model[`CSR_CRMD], crmd_out);
        expect_word({name, " era_out"}, model[`CSR_ERA], era_out);
        expect_word({name, " eentry_out"}, model[`CSR_EENTRY], eentry_out);
        expect_bit({name, " cpu_interrupt"},
                   ref_irq(model[`CSR_CRMD], model[`CSR_ECFG], model[`CSR_ESTAT]),
                   cpu_interrupt);
        @(posedge clk);
        #1;
    endtask

    task automatic data_reg_readback();
        for (int round = 0; round < 4; round++) begin
            foreach (data_regs[i]) begin
                write_reg($sformatf("data %h", data_regs[i]), data_regs[i], next_random());
            end
            foreach (data_regs[i]) begin
                read_and_compare($sformatf("readback %h", data_regs[i]), data_regs[i]);
            end
        end
        // Unmapped writes change nothing
        foreach (bad_addrs[i]) begin
            write_reg($sformatf("unmapped %h", bad_addrs[i]), bad_addrs[i], next_random());
            read_and_compare($sformatf("unmapped %h", bad_addrs[i]), bad_addrs[i]);
        end
        foreach (data_regs[i]) begin
            read_and_compare($sformatf("after unmapped %h", data_regs[i]), data_regs[i]);
        end
        sample_outputs("data regs");
    endtask

    task automatic crmd_write_rules();
        csr_word_t pairs [4] = '{32'h18, 32'h10, 32'h00, 32'h08};
        for (int i = 0; i < 8; i++) begin
            write_reg("crmd random", `CSR_CRMD, next_random());
            read_and_compare("crmd random", `CSR_CRMD);
            sample_outputs("crmd random");
        end
        foreach (pairs[i]) begin
            write_reg($sformatf("crmd pair %h", pairs[i]), `CSR_CRMD, pairs[i]);
            read_and_compare($sformatf("crmd pair %h", pairs[i]), `CSR_CRMD);
        end
    endtask

    task automatic exception_round_trip();
        csr_trap_t t;
        csr_word_t r;
        for (int i = 0; i < 3; i++) begin
            r = next_random();
            write_reg("exc setup", `CSR_CRMD, 32'h8 | (r & 32'h7));
            t            = '0;
            t.exc        = 1'b1;
            t.ecode      = r[13:8];
            t.esubcode   = r[22:14];
            t.era        = next_random();
            t.badv       = next_random();
            pulse_trap(t);
            model[`CSR_PRMD]             = model[`CSR_CRMD] & 32'h7;
            model[`CSR_CRMD][2:0]        = 3'b000;
            model[`CSR_ESTAT][21:16]     = t.ecode;
            model[`CSR_ESTAT][30:22]     = t.esubcode;
            model[`CSR_ERA]              = t.era;
            model[`CSR_BADV]             = t.badv;
            sample_outputs("exc entry");
            read_and_compare("exc prmd", `CSR_PRMD);
            read_and_compare("exc crmd", `CSR_CRMD);
            read_and_compare("exc estat", `CSR_ESTAT);
            read_and_compare("exc era", `CSR_ERA);
            read_and_compare("exc badv", `CSR_BADV);
            t      = '0;
            t.ertn = 1'b1;
            pulse_trap(t);
            model[`CSR_CRMD][2:0] = model[`CSR_PRMD][2:0];
            sample_outputs("exc return");
            read_and_compare("ertn crmd", `CSR_CRMD);
        end
    endtask

    task automatic interrupt_combinations();
        csr_word_t r;
        for (int i = 0; i < 12; i++) begin
            r      = next_random();
            hw_irq = r[9:2];
            model[`CSR_ESTAT][9:2] = r[9:2];
            // One enabled line per round so both outcomes occur
            write_reg("irq ecfg", `CSR_ECFG, 32'h1 << (next_random() % 13));
            write_reg("irq soft", `CSR_ESTAT, next_random());
            write_reg("irq crmd", `CSR_CRMD, 32'h8 | (next_random() & 32'h4));
            read_and_compare("irq estat", `CSR_ESTAT);
            sample_outputs("irq");
        end
        hw_irq = '0;
        model[`CSR_ESTAT][9:2] = 8'h00;
        write_reg("irq end", `CSR_ESTAT, 32'h0);
        write_reg("irq end", `CSR_CRMD, 32'h8);
        sample_outputs("irq end");
    endtask

    // Reads ESTAT until the timer bit sets or the read limit runs out
    task automatic poll_timer_flag(input string name, input int limit);
        csr_word_t rd;
        logic      err;
        logic      seen;
        int        n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            bus_transfer(1'b0, `CSR_ESTAT, 32'h0, rd, err);
            seen = rd[`CSR_TI_BIT];
            n++;
        end
        if (!seen) begin
            timeouts++;
            $display("%s: timer interrupt bit did not set within %0d reads", name, limit);
        end
    endtask

    task automatic timer_flag_is(input string name, input logic exp);
        csr_word_t rd;
        logic      err;
        bus_transfer(1'b0, `CSR_ESTAT, 32'h0, rd, err);
        expect_bit(name, exp, rd[`CSR_TI_BIT]);
    endtask

    task automatic timer_modes();
        csr_word_t   r;
        csr_word_t   rd;
        logic        err;
        logic [29:0] init;
        r    = next_random();
        init = {26'b0, r[3:0] | 4'h1};
        write_reg("oneshot tcfg", `CSR_TCFG, {init, 1'b0, 1'b1});
        poll_timer_flag("oneshot", 4 * int'(init) + 8);
        timer_flag_is("oneshot flag", 1'b1);
        bus_transfer(1'b0, `CSR_TVAL, 32'h0, rd, err);
        expect_word("oneshot tval", 32'h0, rd);
        read_and_compare("oneshot tcfg", `CSR_TCFG);
        write_reg("oneshot ticlr", `CSR_TICLR, 32'h1);
        timer_flag_is("oneshot cleared", 1'b0);
        bus_transfer(1'b0, `CSR_TVAL, 32'h0, rd, err);
        expect_word("oneshot tval held", 32'h0, rd);
        timer_flag_is("oneshot stays clear", 1'b0);

        // Period long enough that a clear is seen before the next expiry
        init = {24'b0, 3'b001, r[6:4]};
        write_reg("periodic tcfg", `CSR_TCFG, {init, 1'b1, 1'b1});
        poll_timer_flag("periodic first", 4 * int'(init) + 8);
        timer_flag_is("periodic first flag", 1'b1);
        write_reg("periodic ticlr", `CSR_TICLR, 32'h1);
        timer_flag_is("periodic cleared", 1'b0);
        poll_timer_flag("periodic again", 4 * int'(init) + 8);
        timer_flag_is("periodic second flag", 1'b1);
        write_reg("timer off", `CSR_TCFG, 32'h0);
        write_reg("timer off ticlr", `CSR_TICLR, 32'h1);
        timer_flag_is("timer off flag", 1'b0);
    endtask

    initial begin
        int n;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        trap    = '0;
        hw_irq  = '0;
        for (int i = 0; i < 16384; i++) begin
            model[i] = '0;
        end
        model[`CSR_CRMD] = `CSR_CRMD_RESET;

        n = 0;
        while (aresetn !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (aresetn !== 1'b1) begin
            timeouts++;
            $display("Reset was never released");
        end else begin
            @(posedge clk);
            #1;

            sample_outputs("reset");
            read_and_compare("reset crmd", `CSR_CRMD);
            data_reg_readback();
            crmd_write_rules();
            exception_round_trip();
            interrupt_combinations();
            timer_modes();

            n = 0;
            while ((word_name.size() > 0 || bit_name.size() > 0) && n < 4) begin
                @(posedge clk);
                n++;
            end
            if (word_name.size() > 0 || bit_name.size() > 0) begin
                timeouts++;
                $display("Queued results were never compared");
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic aresetn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for 8 rising edges
    initial begin
        aresetn = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        aresetn = 1'b1;
    end

endmodule

`default_nettype wire

//--- rtl/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_top
    import csr_pkg::*;
(
    input  logic                        clk,
    input  logic                        aresetn,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  csr_addr_t                   paddr,
    input  csr_word_t                   pwdata,
    output csr_word_t                   prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  csr_trap_t                   trap,
    input  logic [`CSR_HW_IRQ_BITS-1:0] hw_irq,
    output csr_word_t                   crmd_out,
    output csr_word_t                   era_out,
    output csr_word_t                   eentry_out,
    output logic                        cpu_interrupt
);

    csr_wr_t   wr;
    irq_vec_t  ecfg_lie;
    logic      timer_irq;
    csr_word_t prmd;
    csr_word_t estat;
    csr_word_t badv;
    csr_word_t tcfg;
    csr_word_t tval;
    csr_word_t ecfg;
    csr_word_t save0;
    csr_word_t save1;
    csr_word_t save2;
    csr_word_t save3;
    csr_word_t tid;

    csr_apb_port u_apb_port (
        .clk     (clk),
        .aresetn (aresetn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pready  (pready),
        .wr      (wr)
    );

    csr_trap_regs u_trap_regs (
        .clk           (clk),
        .aresetn       (aresetn),
        .wr            (wr),
        .trap          (trap),
        .hw_irq        (hw_irq),
        .ecfg_lie      (ecfg_lie),
        .timer_irq     (timer_irq),
        .crmd          (crmd_out),
        .prmd          (prmd),
        .estat         (estat),
        .era           (era_out),
        .badv          (badv),
        .cpu_interrupt (cpu_interrupt)
    );

    csr_timer u_timer (
        .clk       (clk),
        .aresetn   (aresetn),
        .wr        (wr),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_irq (timer_irq)
    );

    csr_sys_regs u_sys_regs (
        .clk      (clk),
        .aresetn  (aresetn),
        .wr       (wr),
        .ecfg     (ecfg),
        .eentry   (eentry_out),
        .save0    (save0),
        .save1    (save1),
        .save2    (save2),
        .save3    (save3),
        .tid      (tid),
        .ecfg_lie (ecfg_lie)
    );

    csr_read_select u_read_select (
        .paddr   (paddr),
        .crmd    (crmd_out),
        .prmd    (prmd),
        .ecfg    (ecfg),
        .estat   (estat),
        .era     (era_out),
        .badv    (badv),
        .eentry  (eentry_out),
        .save0   (save0),
        .save1   (save1),
        .save2   (save2),
        .save3   (save3),
        .tid     (tid),
        .tcfg    (tcfg),
        .tval    (tval),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

endmodule

`default_nettype wire

//--- rtl/csr_read_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_read_select
    import csr_pkg::*;
(
    input  csr_addr_t paddr,
    input  csr_word_t crmd,
    input  csr_word_t prmd,
    input  csr_word_t ecfg,
    input  csr_word_t estat,
    input  csr_word_t era,
    input  csr_word_t badv,
    input  csr_word_t eentry,
    input  csr_word_t save0,
    input  csr_word_t save1,
    input  csr_word_t save2,
    input  csr_word_t save3,
    input  csr_word_t tid,
    input  csr_word_t tcfg,
    input  csr_word_t tval,
    output csr_word_t prdata,
    output logic      pslverr
);

    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        case (paddr)
            `CSR_CRMD:   prdata = crmd;
            `CSR_PRMD:   prdata = prmd;
            `CSR_ECFG:   prdata = ecfg;
            `CSR_ESTAT:  prdata = estat;
            `CSR_ERA:    prdata = era;
            `CSR_BADV:   prdata = badv;
            `CSR_EENTRY: prdata = eentry;
            `CSR_SAVE0:  prdata = save0;
            `CSR_SAVE1:  prdata = save1;
            `CSR_SAVE2:  prdata = save2;
            `CSR_SAVE3:  prdata = save3;
            `CSR_TID:    prdata = tid;
            `CSR_TCFG:   prdata = tcfg;
            `CSR_TVAL:   prdata = tval;
            // Write-only clear port
            `CSR_TICLR:  prdata = '0;
            default: begin
                prdata  = '0;
                pslverr = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/csr_sys_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_sys_regs
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      aresetn,
    input  csr_wr_t   wr,
    output csr_word_t ecfg,
    output csr_word_t eentry,
    output csr_word_t save0,
    output csr_word_t save1,
    output csr_word_t save2,
    output csr_word_t save3,
    output csr_word_t tid,
    output irq_vec_t  ecfg_lie
);

    irq_vec_t               lie_q;
    logic [`CSR_EENTRY_VA]  eentry_va_q;
    csr_word_t              save_q [4];
    csr_word_t              tid_q;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            lie_q       <= '0;
            eentry_va_q <= '0;
            tid_q       <= '0;
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (wr.en) begin
            if (wr.addr == `CSR_ECFG) begin
                lie_q <= wr.data[`CSR_IRQ_BITS-1:0];
            end
            if (wr.addr == `CSR_EENTRY) begin
                eentry_va_q <= wr.data[`CSR_EENTRY_VA];
            end
            if (wr.addr == `CSR_TID) begin
                tid_q <= wr.data;
            end
            // SAVE0..3 sit on consecutive addresses
            for (int i = 0; i < 4; i++) begin
                if (wr.addr == csr_addr_t'(`CSR_SAVE0 + i)) begin
                    save_q[i] <= wr.data;
                end
            end
        end
    end

    assign ecfg     = {{(32-`CSR_IRQ_BITS){1'b0}}, lie_q};
    assign eentry   = {eentry_va_q, 6'b0};
    assign save0    = save_q[0];
    assign save1    = save_q[1];
    assign save2    = save_q[2];
    assign save3    = save_q[3];
    assign tid      = tid_q;
    assign ecfg_lie = lie_q;

endmodule

`default_nettype wire

//--- rtl/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_timer
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      aresetn,
    input  csr_wr_t   wr,
    output csr_word_t tcfg,
    output csr_word_t tval,
    output logic      timer_irq
);

    logic                        en_q;
    logic                        periodic_q;
    logic [`CSR_TCFG_INITVAL]    initval_q;
    csr_word_t                   tval_q;
    logic                        flag_q;
    logic                        tcfg_load;
    logic                        ticlr_hit;
    logic                        expire;

    assign tcfg_load = wr.en && (wr.addr == `CSR_TCFG);
    assign ticlr_hit = wr.en && (wr.addr == `CSR_TICLR) && wr.data[`CSR_TICLR_CLR];

    // Counter crosses 1 to 0 on this edge
    assign expire = en_q && (tval_q == 32'd1) && !tcfg_load;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            en_q       <= 1'b0;
            periodic_q <= 1'b0;
            initval_q  <= '0;
            tval_q     <= '0;
        end else if (tcfg_load) begin
            en_q       <= wr.data[`CSR_TCFG_EN];
            periodic_q <= wr.data[`CSR_TCFG_PERIODIC];
            initval_q  <= wr.data[`CSR_TCFG_INITVAL];
            tval_q     <= {wr.data[`CSR_TCFG_INITVAL], 2'b00};
        end else if (en_q) begin
            if (tval_q != '0) begin
                tval_q <= tval_q - 32'd1;
            end else if (periodic_q) begin
                tval_q <= {initval_q, 2'b00};
            end
        end
    end

    // Set wins over a clear on the same edge
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            flag_q <= 1'b0;
        end else if (expire) begin
            flag_q <= 1'b1;
        end else if (ticlr_hit) begin
            flag_q <= 1'b0;
        end
    end

    assign tcfg      = {initval_q, periodic_q, en_q};
    assign tval      = tval_q;
    assign timer_irq = flag_q;

    a_tval_frozen: assert property (@(posedge clk) disable iff (!aresetn)
        (!en_q && !tcfg_load) |=> $stable(tval_q))
        else $error("TVAL moved while the timer was disabled");

endmodule

`default_nettype wire

//--- rtl/csr_trap_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_trap_regs
    import csr_pkg::*;
(
    input  logic                        clk,
    input  logic                        aresetn,
    input  csr_wr_t                     wr,
    input  csr_trap_t                   trap,
    input  logic [`CSR_HW_IRQ_BITS-1:0] hw_irq,
    input  irq_vec_t                    ecfg_lie,
    input  logic                        timer_irq,
    output csr_word_t                   crmd,
    output csr_word_t                   prmd,
    output csr_word_t                   estat,
    output csr_word_t                   era,
    output csr_word_t                   badv,
    output logic                        cpu_interrupt
);

    localparam csr_word_t CRMD_RST = `CSR_CRMD_RESET;

    plv_t                        plv_q;
    logic                        ie_q;
    logic                        da_q;
    logic                        pg_q;
    plv_t                        pplv_q;
    logic                        pie_q;
    logic [1:0]                  soft_q;
    logic [`CSR_HW_IRQ_BITS-1:0] hw_q;
    ecode_t                      ecode_q;
    esubcode_t                   esubcode_q;
    csr_word_t                   era_q;
    csr_word_t                   badv_q;
    irq_vec_t                    is_vec;
    logic                        wr_crmd;
    logic                        wr_prmd;
    logic                        wr_estat;
    logic                        wr_era;
    logic                        wr_badv;

    assign wr_crmd  = wr.en && (wr.addr == `CSR_CRMD);
    assign wr_prmd  = wr.en && (wr.addr == `CSR_PRMD);
    assign wr_estat = wr.en && (wr.addr == `CSR_ESTAT);
    assign wr_era   = wr.en && (wr.addr == `CSR_ERA);
    assign wr_badv  = wr.en && (wr.addr == `CSR_BADV);

    // Return beats exception beats software
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            plv_q <= CRMD_RST[`CSR_CRMD_PLV];
            ie_q  <= CRMD_RST[`CSR_CRMD_IE];
            da_q  <= CRMD_RST[`CSR_CRMD_DA];
            pg_q  <= CRMD_RST[`CSR_CRMD_PG];
        end else if (trap.ertn) begin
            plv_q <= pplv_q;
            ie_q  <= pie_q;
        end else if (trap.exc) begin
            plv_q <= '0;
            ie_q  <= 1'b0;
        end else if (wr_crmd) begin
            plv_q <= wr.data[`CSR_CRMD_PLV];
            ie_q  <= wr.data[`CSR_CRMD_IE];
            // DA/PG only take a legal one-hot pair
            if (wr.data[`CSR_CRMD_DA] ^ wr.data[`CSR_CRMD_PG]) begin
                da_q <= wr.data[`CSR_CRMD_DA];
                pg_q <= wr.data[`CSR_CRMD_PG];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            pplv_q     <= '0;
            pie_q      <= 1'b0;
            ecode_q    <= '0;
            esubcode_q <= '0;
            era_q      <= '0;
            badv_q     <= '0;
            soft_q     <= '0;
        end else if (trap.exc) begin
            pplv_q     <= plv_q;
            pie_q      <= ie_q;
            ecode_q    <= trap.ecode;
            esubcode_q <= trap.esubcode;
            era_q      <= trap.era;
            badv_q     <= trap.badv;
        end else begin
            if (wr_prmd) begin
                pplv_q <= wr.data[`CSR_PRMD_PPLV];
                pie_q  <= wr.data[`CSR_PRMD_PIE];
            end
            if (wr_estat) begin
                soft_q <= wr.data[`CSR_ESTAT_SOFT];
            end
            if (wr_era) begin
                era_q <= wr.data;
            end
            if (wr_badv) begin
                badv_q <= wr.data;
            end
        end
    end

    // Hardware lines are sampled once
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            hw_q <= '0;
        end else begin
            hw_q <= hw_irq;
        end
    end

    always_comb begin
        is_vec                   = '0;
        is_vec[`CSR_ESTAT_SOFT]  = soft_q;
        is_vec[`CSR_ESTAT_HW]    = hw_q;
        is_vec[`CSR_TI_BIT]      = timer_irq;

        crmd                 = '0;
        crmd[`CSR_CRMD_PLV]  = plv_q;
        crmd[`CSR_CRMD_IE]   = ie_q;
        crmd[`CSR_CRMD_DA]   = da_q;
        crmd[`CSR_CRMD_PG]   = pg_q;

        prmd                 = '0;
        prmd[`CSR_PRMD_PPLV] = pplv_q;
        prmd[`CSR_PRMD_PIE]  = pie_q;

        estat                       = '0;
        estat[`CSR_IRQ_BITS-1:0]    = is_vec;
        estat[`CSR_ESTAT_ECODE]     = ecode_q;
        estat[`CSR_ESTAT_ESUBCODE]  = esubcode_q;
    end

    assign era           = era_q;
    assign badv          = badv_q;
    assign cpu_interrupt = ie_q && |(is_vec & ecfg_lie);

    a_trap_exclusive: assert property (@(posedge clk) disable iff (!aresetn)
        !(trap.exc && trap.ertn))
        else $error("exception entry and return in the same cycle");

endmodule

`default_nettype wire

//--- rtl/csr_apb_port.sv
`timescale 1ns/1ps
`default_nettype none

module csr_apb_port
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      aresetn,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  csr_addr_t paddr,
    input  csr_word_t pwdata,
    output logic      pready,
    output csr_wr_t   wr
);

    apb_state_t phase;
    apb_state_t state_q;
    logic       access_ok;

    // Phase seen on the bus this cycle
    always_comb begin
        if (!psel) begin
            phase = IDLE;
        end else if (!penable) begin
            phase = SETUP;
        end else begin
            phase = ACCESS;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state_q <= IDLE;
        end else begin
            state_q <= phase;
        end
    end

    // Zero wait states put every access right after its setup
    assign access_ok = (phase == ACCESS) && (state_q == SETUP);
    assign pready    = (phase == ACCESS);

    always_comb begin
        wr.en   = access_ok && pwrite;
        wr.addr = paddr;
        wr.data = pwdata;
    end

    a_access_after_setup: assert property (@(posedge clk) disable iff (!aresetn)
        $rose(penable) |-> state_q == SETUP)
        else $error("penable rose without a setup cycle");

    a_addr_stable: assert property (@(posedge clk) disable iff (!aresetn)
        access_ok |-> $stable(paddr))
        else $error("paddr changed between setup and access");

endmodule

`default_nettype wire

//--- rtl/csr_pkg.sv
`default_nettype none

`include "csr_defines.svh"

package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [`CSR_IRQ_BITS-1:0] irq_vec_t;

    // One completed APB write
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_word_t data;
    } csr_wr_t;

    // Trap sideband from the core
    typedef struct packed {
        logic      exc;
        logic      ertn;
        ecode_t    ecode;
        esubcode_t esubcode;
        csr_word_t era;
        csr_word_t badv;
    } csr_trap_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_t;

endpackage

`default_nettype wire

//--- rtl/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Register addresses
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00C
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033
`define CSR_TID     14'h040
`define CSR_TCFG    14'h041
`define CSR_TVAL    14'h042
`define CSR_TICLR   14'h044

// Interrupt vector layout shared by ESTAT and ECFG
`define CSR_IRQ_BITS     13
`define CSR_HW_IRQ_BITS  8
`define CSR_TI_BIT       11

// Field positions
`define CSR_CRMD_PLV        1:0
`define CSR_CRMD_IE         2
`define CSR_CRMD_DA         3
`define CSR_CRMD_PG         4
`define CSR_PRMD_PPLV       1:0
`define CSR_PRMD_PIE        2
`define CSR_ESTAT_SOFT      1:0
`define CSR_ESTAT_HW        9:2
`define CSR_ESTAT_ECODE     21:16
`define CSR_ESTAT_ESUBCODE  30:22
`define CSR_TCFG_EN         0
`define CSR_TCFG_PERIODIC   1
`define CSR_TCFG_INITVAL    31:2
`define CSR_EENTRY_VA       31:6
`define CSR_TICLR_CLR       0

// Direct address translation after reset
`define CSR_CRMD_RESET  32'h0000_0008

`endif
